// ==== source/frame_pkg.sv ====
package frame_pkg;

    // Fixed bank arrangement of the shared store
    localparam int NUM_BANKS = 4;
    localparam int BANK_W    = 2;
    localparam int DATA_W    = 16;
    localparam int MASK_W    = 2;

    // Defaults for the top level parameters
    localparam int DEF_ADDR_W       = 8;
    localparam int DEF_QUEUE_DEPTH  = 4;
    localparam int DEF_READ_LATENCY = 2;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_t;

    // Client or download request, addr is a word address
    typedef struct packed {
        logic              valid;
        mem_op_t           op;
        logic [15:0]       addr;
        logic [DATA_W-1:0] data;
        logic [MASK_W-1:0] mask;
    } mem_req_t;

    typedef struct packed {
        logic              rdy;
        logic [DATA_W-1:0] data;
    } mem_resp_t;

    // Byte wide download channel
    typedef struct packed {
        logic        wr;
        logic [17:0] addr;
        logic [7:0]  data;
    } ioctl_t;

    // Command granted to the store
    typedef struct packed {
        logic              valid;
        mem_op_t           op;
        logic [BANK_W-1:0] bank;
        logic [15:0]       addr;
        logic [DATA_W-1:0] data;
        logic [MASK_W-1:0] mask;
    } mem_cmd_t;

    typedef struct packed {
        logic              valid;
        logic [BANK_W-1:0] bank;
        logic [DATA_W-1:0] data;
    } mem_ret_t;

endpackage

// ==== source/rom_download.sv ====
module rom_download
    import frame_pkg::*;
#(
    parameter int ADDR_W = DEF_ADDR_W
) (
    input  logic     sample,
    input  logic     reset,
    input  ioctl_t   ioctl,
    output mem_req_t dl_req,
    input  logic     dl_grant,
    output logic     ioctl_credit
);

    // Word address covers the bank select and the in-bank address
    logic [ADDR_W+BANK_W-1:0] word_addr;

    logic              pend_valid;
    logic [15:0]       pend_addr;
    logic [DATA_W-1:0] pend_data;
    logic [MASK_W-1:0] pend_mask;

    assign word_addr = ioctl.addr[ADDR_W+BANK_W:1];

    always_ff @(posedge sample) begin
        if (reset) begin
            pend_valid   <= 1'b0;
            ioctl_credit <= 1'b0;
        end else begin
            ioctl_credit <= dl_grant;
            if (dl_grant) begin
                pend_valid <= 1'b0;
            end
            // Host holds one credit, so no overlap with a pending write
            if (ioctl.wr) begin
                pend_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge sample) begin
        if (ioctl.wr) begin
            pend_addr <= 16'(word_addr);
            pend_data <= {2{ioctl.data}};
            // Even byte goes low, odd byte goes high
            pend_mask <= ioctl.addr[0] ? 2'b10 : 2'b01;
        end
    end

    always_comb begin
        dl_req.valid = pend_valid;
        dl_req.op    = OP_WRITE;
        dl_req.addr  = pend_addr;
        dl_req.data  = pend_data;
        dl_req.mask  = pend_mask;
    end

endmodule

// ==== source/bank_port.sv ====
module bank_port
    import frame_pkg::*;
#(
    parameter int ADDR_W      = DEF_ADDR_W,
    parameter int QUEUE_DEPTH = DEF_QUEUE_DEPTH,
    parameter int BANK_ID     = 0,
    parameter int WRITABLE    = 1
) (
    input  logic      sample,
    input  logic      reset,
    input  mem_req_t  client_req,
    output logic      client_credit,
    output mem_req_t  head_req,
    input  logic      grant,
    input  mem_ret_t  mem_ret,
    output mem_resp_t client_resp
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    mem_req_t queue [QUEUE_DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    mem_req_t          push_entry;
    logic              resp_rdy;
    logic [DATA_W-1:0] resp_data;

    always_comb begin
        push_entry      = client_req;
        push_entry.addr = 16'(client_req.addr[ADDR_W-1:0]);
        // Read only banks turn writes into reads
        if (WRITABLE == 0) begin
            push_entry.op = OP_READ;
        end
    end

    always_ff @(posedge sample) begin
        if (client_req.valid) begin
            queue[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge sample) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            client_credit <= 1'b0;
        end else begin
            client_credit <= grant;
            if (client_req.valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (grant) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({client_req.valid, grant})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_comb begin
        head_req       = queue[rd_ptr];
        head_req.valid = (count != '0);
    end

    // Capture returns tagged for this bank
    always_ff @(posedge sample) begin
        if (reset) begin
            resp_rdy <= 1'b0;
        end else begin
            resp_rdy <= mem_ret.valid && (mem_ret.bank == BANK_W'(BANK_ID));
        end
    end

    always_ff @(posedge sample) begin
        resp_data <= mem_ret.data;
    end

    assign client_resp.rdy  = resp_rdy;
    assign client_resp.data = resp_data;

endmodule

// ==== source/bank_arbiter.sv ====
module bank_arbiter
    import frame_pkg::*;
#(
    parameter int ADDR_W = DEF_ADDR_W
) (
    input  logic                 sample,
    input  logic                 reset,
    input  logic                 downloading,
    input  mem_req_t             dl_req,
    output logic                 dl_grant,
    input  mem_req_t             bank_head [NUM_BANKS],
    output logic [NUM_BANKS-1:0] bank_grant,
    output mem_cmd_t             mem_cmd
);

    // Last bank served, search starts one past it
    logic [BANK_W-1:0] rr_last;
    logic [BANK_W-1:0] cand;
    logic [BANK_W-1:0] sel;
    logic              found;

    always_comb begin
        found = 1'b0;
        sel   = rr_last;
        cand  = rr_last;
        // Banks wait for the download channel and for the whole download
        if (!dl_req.valid && !downloading) begin
            for (int k = 1; k <= NUM_BANKS; k++) begin
                cand = rr_last + BANK_W'(k);
                if (!found && bank_head[cand].valid) begin
                    found = 1'b1;
                    sel   = cand;
                end
            end
        end
    end

    always_comb begin
        dl_grant   = dl_req.valid;
        bank_grant = '0;
        mem_cmd    = '0;
        if (dl_req.valid) begin
            mem_cmd.valid = 1'b1;
            mem_cmd.op    = dl_req.op;
            // Download word address carries the bank in its top bits
            mem_cmd.bank  = dl_req.addr[ADDR_W +: BANK_W];
            mem_cmd.addr  = 16'(dl_req.addr[ADDR_W-1:0]);
            mem_cmd.data  = dl_req.data;
            mem_cmd.mask  = dl_req.mask;
        end else if (found) begin
            bank_grant[sel] = 1'b1;
            mem_cmd.valid   = 1'b1;
            mem_cmd.op      = bank_head[sel].op;
            mem_cmd.bank    = sel;
            mem_cmd.addr    = bank_head[sel].addr;
            mem_cmd.data    = bank_head[sel].data;
            mem_cmd.mask    = bank_head[sel].mask;
        end
    end

    always_ff @(posedge sample) begin
        if (reset) begin
            // Bank 0 goes first after reset
            rr_last <= BANK_W'(NUM_BANKS - 1);
        end else if (found) begin
            rr_last <= sel;
        end
    end

endmodule

// ==== source/mem_array.sv ====
module mem_array
    import frame_pkg::*;
#(
    parameter int ADDR_W       = DEF_ADDR_W,
    parameter int READ_LATENCY = DEF_READ_LATENCY
) (
    input  logic     sample,
    input  logic     reset,
    input  mem_cmd_t mem_cmd,
    output mem_ret_t mem_ret
);

    localparam int WORDS = NUM_BANKS * (2 ** ADDR_W);

    logic [DATA_W-1:0] store [WORDS];

    logic [BANK_W+ADDR_W-1:0] index;
    logic [READ_LATENCY-1:0]  pipe_valid;
    logic [BANK_W-1:0]        pipe_bank [READ_LATENCY];
    logic [DATA_W-1:0]        pipe_data [READ_LATENCY];

    assign index = {mem_cmd.bank, mem_cmd.addr[ADDR_W-1:0]};

    // Byte masked write at the grant edge
    always_ff @(posedge sample) begin
        if (mem_cmd.valid && mem_cmd.op == OP_WRITE) begin
            for (int i = 0; i < MASK_W; i++) begin
                if (mem_cmd.mask[i]) begin
                    store[index][8*i +: 8] <= mem_cmd.data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge sample) begin
        if (reset) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid[0] <= mem_cmd.valid && (mem_cmd.op == OP_READ);
            for (int i = 1; i < READ_LATENCY; i++) begin
                pipe_valid[i] <= pipe_valid[i-1];
            end
        end
    end

    // First stage samples the array, later stages just delay
    always_ff @(posedge sample) begin
        pipe_bank[0] <= mem_cmd.bank;
        pipe_data[0] <= store[index];
        for (int i = 1; i < READ_LATENCY; i++) begin
            pipe_bank[i] <= pipe_bank[i-1];
            pipe_data[i] <= pipe_data[i-1];
        end
    end

    assign mem_ret.valid = pipe_valid[READ_LATENCY-1];
    assign mem_ret.bank  = pipe_bank[READ_LATENCY-1];
    assign mem_ret.data  = pipe_data[READ_LATENCY-1];

endmodule

// ==== source/rom_frame.sv ====
module rom_frame
    import frame_pkg::*;
#(
    parameter int ADDR_W       = DEF_ADDR_W,
    parameter int QUEUE_DEPTH  = DEF_QUEUE_DEPTH,
    parameter int READ_LATENCY = DEF_READ_LATENCY
) (
    input  logic                 sample,
    input  logic                 reset,
    input  logic                 downloading,
    input  ioctl_t               ioctl,
    output logic                 ioctl_credit,
    input  mem_req_t             bank_req [NUM_BANKS],
    output logic [NUM_BANKS-1:0] bank_credit,
    output mem_resp_t            bank_resp [NUM_BANKS]
);

    mem_req_t             dl_req;
    logic                 dl_grant;
    mem_req_t             bank_head [NUM_BANKS];
    logic [NUM_BANKS-1:0] bank_grant;
    mem_cmd_t             mem_cmd;
    mem_ret_t             mem_ret;

    rom_download #(
        .ADDR_W       (ADDR_W)
    ) i_download (
        .sample       (sample),
        .reset        (reset),
        .ioctl        (ioctl),
        .dl_req       (dl_req),
        .dl_grant     (dl_grant),
        .ioctl_credit (ioctl_credit)
    );

    // Bank 0 is read/write, the rest are read only
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        bank_port #(
            .ADDR_W        (ADDR_W),
            .QUEUE_DEPTH   (QUEUE_DEPTH),
            .BANK_ID       (b),
            .WRITABLE      ((b == 0) ? 1 : 0)
        ) i_port (
            .sample        (sample),
            .reset         (reset),
            .client_req    (bank_req[b]),
            .client_credit (bank_credit[b]),
            .head_req      (bank_head[b]),
            .grant         (bank_grant[b]),
            .mem_ret       (mem_ret),
            .client_resp   (bank_resp[b])
        );
    end

    bank_arbiter #(
        .ADDR_W      (ADDR_W)
    ) i_arbiter (
        .sample      (sample),
        .reset       (reset),
        .downloading (downloading),
        .dl_req      (dl_req),
        .dl_grant    (dl_grant),
        .bank_head   (bank_head),
        .bank_grant  (bank_grant),
        .mem_cmd     (mem_cmd)
    );

    mem_array #(
        .ADDR_W       (ADDR_W),
        .READ_LATENCY (READ_LATENCY)
    ) i_store (
        .sample       (sample),
        .reset        (reset),
        .mem_cmd      (mem_cmd),
        .mem_ret      (mem_ret)
    );

endmodule

// ==== dv/rom_frame_properties.sv ====
module rom_frame_properties
    import frame_pkg::*;
#(
    parameter int QUEUE_DEPTH = DEF_QUEUE_DEPTH
) (
    input logic                 sample,
    input logic                 reset,
    input logic                 downloading,
    input logic                 ioctl_credit,
    input mem_req_t             bank_req [NUM_BANKS],
    input logic [NUM_BANKS-1:0] bank_credit,
    input mem_resp_t            bank_resp [NUM_BANKS]
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [NUM_BANKS-1:0] rdy_vec;

    // Requests presented minus credits returned
    int outstanding [NUM_BANKS];

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            rdy_vec[b] = bank_resp[b].rdy;
        end
    end

    always_ff @(posedge sample) begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (reset) begin
                outstanding[b] <= 0;
            end else begin
                outstanding[b] <= outstanding[b] + int'(bank_req[b].valid)
                                  - int'(bank_credit[b]);
            end
        end
    end

    quiet_in_reset: assert property (@(posedge sample)
        reset |=> (rdy_vec == '0 && bank_credit == '0 && !ioctl_credit))
        else $error("rdy or a credit was active during reset");

    quiet_in_download: assert property (@(posedge sample) disable iff (reset)
        downloading |-> (rdy_vec == '0 && bank_credit == '0))
        else $error("A bank responded while downloading was high");

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        req_needs_credit: assert property (@(posedge sample) disable iff (reset)
            bank_req[b].valid |-> (outstanding[b] < QUEUE_DEPTH))
            else $error("Request presented on bank %0d with no credit left", b);

        credit_bounded: assert property (@(posedge sample) disable iff (reset)
            bank_credit[b] |-> (outstanding[b] > 0))
            else $error("Bank %0d returned more credits than requests", b);
    end

endmodule

bind rom_frame rom_frame_properties #(
    .QUEUE_DEPTH  (QUEUE_DEPTH)
) i_properties (
    .sample       (sample),
    .reset        (reset),
    .downloading  (downloading),
    .ioctl_credit (ioctl_credit),
    .bank_req     (bank_req),
    .bank_credit  (bank_credit),
    .bank_resp    (bank_resp)
);

// ==== dv/rom_frame_tb.sv ====
module rom_frame_tb
    import frame_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_W       = 8;
    localparam int QUEUE_DEPTH  = 4;
    localparam int READ_LATENCY = 2;
    localparam int WORDS        = 2 ** ADDR_W;
    localparam int TIMEOUT      = 200;

    logic                 sample;
    logic                 reset;
    logic                 downloading;
    ioctl_t               ioctl;
    logic                 ioctl_credit;
    mem_req_t             bank_req [NUM_BANKS];
    logic [NUM_BANKS-1:0] bank_credit;
    mem_resp_t            bank_resp [NUM_BANKS];

    // Reference store, pending reads and client credits
    logic [DATA_W-1:0] model [NUM_BANKS][WORDS];
    logic [DATA_W-1:0] expected [NUM_BANKS][$];
    int                known [NUM_BANKS][$];
    int                credits [NUM_BANKS];
    logic              host_credit;
    integer            seed;

    rom_frame #(
        .ADDR_W       (ADDR_W),
        .QUEUE_DEPTH  (QUEUE_DEPTH),
        .READ_LATENCY (READ_LATENCY)
    ) i_dut (
        .sample       (sample),
        .reset        (reset),
        .downloading  (downloading),
        .ioctl        (ioctl),
        .ioctl_credit (ioctl_credit),
        .bank_req     (bank_req),
        .bank_credit  (bank_credit),
        .bank_resp    (bank_resp)
    );

    initial begin
        sample = 1'b0;
        forever #2 sample = ~sample;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    function automatic logic any_rdy();
        logic seen;
        seen = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            seen |= bank_resp[b].rdy;
        end
        return seen;
    endfunction

    function automatic logic all_idle();
        logic idle;
        idle = host_credit;
        for (int b = 0; b < NUM_BANKS; b++) begin
            idle &= (expected[b].size() == 0) && (credits[b] == QUEUE_DEPTH);
        end
        return idle;
    endfunction

    task automatic clear_requests();
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_req[b].valid <= 1'b0;
        end
    endtask

    task automatic next_cycle();
        @(posedge sample);
        clear_requests();
    endtask

    task automatic step_or_timeout(inout int cycles, input string what);
        next_cycle();
        cycles++;
        if (cycles > TIMEOUT) begin
            abort_run({"Timeout while waiting for ", what});
        end
    endtask

    // Model follows the queue order, so reads expect the data at send time
    task automatic send_req(input int b, input mem_op_t op, input int addr,
                            input logic [DATA_W-1:0] data, input logic [MASK_W-1:0] mask);
        mem_req_t req;
        int       cycles;
        cycles = 0;
        while (credits[b] == 0) begin
            step_or_timeout(cycles, "a bank credit");
        end
        req.valid = 1'b1;
        req.op    = op;
        req.addr  = 16'(addr);
        req.data  = data;
        req.mask  = mask;
        bank_req[b] <= req;
        credits[b]--;
        if (op == OP_WRITE && b == 0) begin
            for (int i = 0; i < MASK_W; i++) begin
                if (mask[i]) begin
                    model[b][addr][8*i +: 8] = data[8*i +: 8];
                end
            end
        end else begin
            expected[b].push_back(model[b][addr]);
        end
    endtask

    task automatic wait_host_credit();
        int cycles;
        cycles = 0;
        while (!host_credit) begin
            step_or_timeout(cycles, "the download credit");
        end
    endtask

    // Even byte first, then odd byte of the same word
    task automatic download_word(input int b, input int addr, input logic [DATA_W-1:0] data);
        ioctl_t cmd;
        for (int sel = 0; sel < 2; sel++) begin
            wait_host_credit();
            cmd.wr   = 1'b1;
            cmd.addr = 18'((b * WORDS + addr) * 2 + sel);
            cmd.data = data[8*sel +: 8];
            ioctl <= cmd;
            host_credit = 1'b0;
            @(posedge sample);
            ioctl.wr <= 1'b0;
        end
        model[b][addr] = data;
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        next_cycle();
        while (!all_idle()) begin
            step_or_timeout(cycles, "reads and credits to return");
        end
    endtask

    task automatic read_random(input int b);
        send_req(b, OP_READ, known[b][rand_below(known[b].size())], '0, '0);
    endtask

    // Outputs sampled mid cycle
    always @(negedge sample) begin
        if (!reset) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (bank_credit[b]) begin
                    credits[b]++;
                end
                if (bank_resp[b].rdy) begin
                    assert (expected[b].size() > 0)
                        else abort_run($sformatf("Read response on bank %0d with none pending", b));
                    assert (bank_resp[b].data == expected[b][0])
                        else abort_run($sformatf("CHECK FAILED: bank_resp[%0d].data = %h, expected %h",
                                                 b, bank_resp[b].data, expected[b][0]));
                    void'(expected[b].pop_front());
                end
            end
            if (ioctl_credit) begin
                host_credit = 1'b1;
            end
        end
    end

    initial begin
        logic [DATA_W-1:0] data;
        int                addr;
        seed        = 32'h97524e67;
        reset       = 1'b1;
        downloading = 1'b0;
        ioctl       = '0;
        host_credit = 1'b1;
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_req[b] = '0;
            credits[b]  = QUEUE_DEPTH;
        end
        repeat (16) @(posedge sample);
        reset <= 1'b0;

        // Quiet outputs with no stimulus
        repeat (8) begin
            @(negedge sample);
            assert (bank_credit == '0 && !ioctl_credit && !any_rdy())
                else abort_run("An output became active after reset with no stimulus");
        end
        @(posedge sample);

        // Download into every bank, then read each word back
        downloading <= 1'b1;
        @(posedge sample);
        for (int b = 0; b < NUM_BANKS; b++) begin
            repeat (6) begin
                addr = rand_below(WORDS);
                data = 16'($random(seed));
                download_word(b, addr, data);
                known[b].push_back(addr);
            end
        end
        wait_host_credit();
        downloading <= 1'b0;
        next_cycle();
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int i = 0; i < known[b].size(); i++) begin
                send_req(b, OP_READ, known[b][i], '0, '0);
                next_cycle();
            end
        end
        drain();

        // Byte masked writes on bank 0
        addr = known[0][0];
        for (int m = 1; m < 4; m++) begin
            send_req(0, OP_WRITE, addr, 16'($random(seed)), 2'(m));
            next_cycle();
            send_req(0, OP_READ, addr, '0, '0);
            next_cycle();
        end
        drain();

        // Writes on read only banks act as reads
        for (int b = 1; b < NUM_BANKS; b++) begin
            send_req(b, OP_WRITE, known[b][0], 16'($random(seed)), 2'b11);
            next_cycle();
            send_req(b, OP_READ, known[b][0], '0, '0);
            next_cycle();
        end
        drain();

        // All queues full at once
        repeat (QUEUE_DEPTH) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                read_random(b);
            end
            next_cycle();
        end
        drain();

        // Bank reads held off by a download
        downloading <= 1'b1;
        @(posedge sample);
        for (int b = 0; b < NUM_BANKS - 1; b++) begin
            read_random(b);
        end
        next_cycle();
        addr = rand_below(WORDS);
        download_word(3, addr, 16'($random(seed)));
        known[3].push_back(addr);
        repeat (8) begin
            @(negedge sample);
            assert (!any_rdy()) else abort_run("A read response arrived while downloading");
        end
        @(posedge sample);
        wait_host_credit();
        downloading <= 1'b0;
        next_cycle();
        send_req(3, OP_READ, addr, '0, '0);
        drain();

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== rom_frame.f ====
source/frame_pkg.sv
source/rom_download.sv
source/bank_port.sv
source/bank_arbiter.sv
source/mem_array.sv
source/rom_frame.sv
dv/rom_frame_properties.sv
dv/rom_frame_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the log holds the pass message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rom_frame_tb -f rom_frame.f &&
    ./obj_dir/Vrom_frame_tb 2>&1 | tee sim.log
grep -q "Test completed successfully" sim.log &&
    echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }
